//--- src/hangmanPkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// shared constants for the hangman game core
// word geometry, APB register map,
// status word layout and round FSM states
// ~~~~~~~~~~~~~~~~~~~~

package hangmanPkg;

    // word geometry
    localparam int letterCount = 5;
    localparam int letterWidth = 8;
    localparam int mistakeWidth = 3;

    // APB byte offsets
    localparam logic [7:0] addrWordLo = 8'h00;
    localparam logic [7:0] addrWordHi = 8'h04;
    localparam logic [7:0] addrCtrl = 8'h08;
    localparam logic [7:0] addrGuess = 8'h0C;
    localparam logic [7:0] addrStatus = 8'h10;

    // single-bit status flags
    localparam int statusBusy = 0;
    localparam int statusReady = 1;
    localparam int statusWin = 2;
    localparam int statusLose = 3;
    localparam int statusMiss = 4;

    // multi-bit status fields, lsb positions
    localparam int statusHitsLsb = 8;
    localparam int statusMistakesLsb = 12;
    localparam int statusRevealLsb = 16;

    // round FSM
    typedef enum logic [2:0] {
        setup = 3'd0,
        scan = 3'd1,
        update = 3'd2,
        waitGuess = 3'd3,
        over = 3'd4
    } gameState;

endpackage

//--- src/apbRegs.sv
// ~~~~~~~~~~~~~~~~~~~~
// APB slave for the game core
// write strobes for word, start and guess,
// refusal through pslverr, status readback
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module apbRegs (
    input  logic clk,
    input  logic nRst,
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic [7:0] paddr,
    input  logic [31:0] pwdata,
    input  logic busy,
    input  logic ready,
    input  logic playing,
    input  logic [hangmanPkg::letterCount-1:0] reveal,
    input  logic [hangmanPkg::mistakeWidth-1:0] hits,
    input  logic [hangmanPkg::mistakeWidth-1:0] mistakes,
    input  logic lastMiss,
    input  logic win,
    input  logic lose,
    output logic [31:0] prdata,
    output logic pready,
    output logic pslverr,
    output logic wordWrLo,
    output logic wordWrHi,
    output logic [31:0] wordData,
    output logic startWr,
    output logic guessWr,
    output logic [hangmanPkg::letterWidth-1:0] guessData
);
    import hangmanPkg::*;

    logic wrAccess;
    logic selWordLo;
    logic selWordHi;
    logic selCtrl;
    logic selGuess;
    logic refuse;
    logic [31:0] wordLoCopy;
    logic [letterWidth-1:0] wordHiCopy;
    logic [31:0] statusWord;

    // zero wait states, transfer completes in the access phase
    assign pready = 1'b1;
    assign wrAccess = psel && penable && pwrite;

    assign selWordLo = (paddr == addrWordLo);
    assign selWordHi = (paddr == addrWordHi);
    assign selCtrl = (paddr == addrCtrl);
    assign selGuess = (paddr == addrGuess);

    // word and start only between rounds, guesses only when ready
    assign refuse = ((selWordLo || selWordHi || selCtrl) && playing)
                  || (selGuess && !ready);
    assign pslverr = wrAccess && refuse;

    assign wordWrLo = wrAccess && selWordLo && !refuse;
    assign wordWrHi = wrAccess && selWordHi && !refuse;
    // bit 0 of the control register is the start bit
    assign startWr = wrAccess && selCtrl && pwdata[0] && !refuse;
    assign guessWr = wrAccess && selGuess && !refuse;

    assign wordData = pwdata;
    assign guessData = pwdata[letterWidth-1:0];

    // readback copy of the secret word
    always_ff @(posedge clk) begin
        if (wordWrLo) begin
            wordLoCopy <= pwdata;
        end
        if (wordWrHi) begin
            wordHiCopy <= pwdata[letterWidth-1:0];
        end
    end

    always_comb begin
        statusWord = '0;
        statusWord[statusBusy] = busy;
        statusWord[statusReady] = ready;
        statusWord[statusWin] = win;
        statusWord[statusLose] = lose;
        statusWord[statusMiss] = lastMiss;
        statusWord[statusHitsLsb +: mistakeWidth] = hits;
        statusWord[statusMistakesLsb +: mistakeWidth] = mistakes;
        statusWord[statusRevealLsb +: letterCount] = reveal;
    end

    // read mux, unmapped offsets read as zero
    always_comb begin
        case (paddr)
            addrWordLo: prdata = wordLoCopy;
            addrWordHi: prdata = {{(32 - letterWidth){1'b0}}, wordHiCopy};
            addrStatus: prdata = statusWord;
            default: prdata = '0;
        endcase
    end

endmodule

//--- src/gameControl.sv
// ~~~~~~~~~~~~~~~~~~~~
// round FSM
// start, letter scan, score commit,
// end of round detection
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module gameControl (
    input  logic clk,
    input  logic nRst,
    input  logic startWr,
    input  logic guessWr,
    input  logic win,
    input  logic lose,
    output logic [2:0] scanIndex,
    output logic scanEn,
    output logic hitValid,
    output logic clearScore,
    output logic commit,
    output logic busy,
    output logic ready,
    output logic playing
);
    import hangmanPkg::*;

    localparam logic [2:0] lastIndex = 3'(letterCount - 1);

    gameState state;
    gameState nextState;
    logic roundEnded;

    // score flags are already settled when the FSM is back in waitGuess
    assign roundEnded = win || lose;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state <= setup;
            scanIndex <= '0;
            hitValid <= 1'b0;
            busy <= 1'b0;
        end else begin
            state <= nextState;
            // compare result lands one cycle after its index
            hitValid <= scanEn;
            if (state == scan) begin
                scanIndex <= scanIndex + 3'd1;
            end else begin
                scanIndex <= '0;
            end
            // set on an accepted guess, dropped once back in waitGuess
            if (state == waitGuess) begin
                busy <= guessWr && !roundEnded;
            end
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            setup: begin
                if (startWr) begin
                    nextState = waitGuess;
                end
            end
            waitGuess: begin
                if (roundEnded) begin
                    nextState = over;
                end else if (guessWr) begin
                    nextState = scan;
                end
            end
            scan: begin
                if (scanIndex == lastIndex) begin
                    nextState = update;
                end
            end
            update: begin
                nextState = waitGuess;
            end
            over: begin
                if (startWr) begin
                    nextState = waitGuess;
                end
            end
            default: begin
                nextState = setup;
            end
        endcase
    end

    assign scanEn = (state == scan);
    assign commit = (state == update);
    assign clearScore = startWr && ((state == setup) || (state == over));
    assign ready = (state == waitGuess) && !busy;
    // a round runs from start until win or lose
    assign playing = (state == waitGuess) || (state == scan) || (state == update);

endmodule

//--- src/letterMatch.sv
// ~~~~~~~~~~~~~~~~~~~~
// secret word and guess storage
// registered per-position compare
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module letterMatch (
    input  logic clk,
    input  logic nRst,
    input  logic wordWrLo,
    input  logic wordWrHi,
    input  logic [31:0] wordData,
    input  logic guessWr,
    input  logic [hangmanPkg::letterWidth-1:0] guessData,
    input  logic [2:0] scanIndex,
    input  logic scanEn,
    output logic hit
);
    import hangmanPkg::*;

    logic [letterWidth-1:0] letters [letterCount];
    logic [letterWidth-1:0] guessReg;

    // letter 0 sits in the low byte of the low word
    always_ff @(posedge clk) begin
        if (wordWrLo) begin
            for (int i = 0; i < 4; i++) begin
                letters[i] <= wordData[i*letterWidth +: letterWidth];
            end
        end
        if (wordWrHi) begin
            letters[4] <= wordData[letterWidth-1:0];
        end
        if (guessWr) begin
            guessReg <= guessData;
        end
    end

    // one position per cycle while scanning
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            hit <= 1'b0;
        end else if (scanEn) begin
            hit <= (letters[scanIndex] == guessReg);
        end else begin
            hit <= 1'b0;
        end
    end

endmodule

//--- src/scoreKeeper.sv
// ~~~~~~~~~~~~~~~~~~~~
// score state for one round
// revealed mask, hit and mistake counters,
// win and lose flags
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module scoreKeeper #(
    parameter int maxMistakes = 6
) (
    input  logic clk,
    input  logic nRst,
    input  logic clearScore,
    input  logic hitValid,
    input  logic hit,
    input  logic [2:0] scanIndex,
    input  logic commit,
    output logic [hangmanPkg::letterCount-1:0] reveal,
    output logic [hangmanPkg::mistakeWidth-1:0] hits,
    output logic [hangmanPkg::mistakeWidth-1:0] mistakes,
    output logic lastMiss,
    output logic win,
    output logic lose
);
    import hangmanPkg::*;

    logic [2:0] hitIndex;
    logic [letterCount-1:0] pendMask;
    logic [letterCount-1:0] maskNext;
    logic [mistakeWidth-1:0] pendCount;
    logic [mistakeWidth-1:0] countNext;
    logic [mistakeWidth:0] hitSum;
    logic [mistakeWidth-1:0] mistakesNext;
    logic [letterCount-1:0] revealNext;
    logic winNext;

    // index of the position whose compare arrives this cycle
    always_ff @(posedge clk) begin
        hitIndex <= scanIndex;
    end

    // last position scores in the same cycle as commit
    always_comb begin
        maskNext = pendMask;
        countNext = pendCount;
        if (hitValid && hit) begin
            maskNext[hitIndex] = 1'b1;
            countNext = pendCount + 1'b1;
        end
        hitSum = hits + countNext;
        mistakesNext = (countNext == '0) ? mistakes + 1'b1 : mistakes;
        revealNext = reveal | maskNext;
        winNext = &revealNext;
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            pendMask <= '0;
            pendCount <= '0;
            reveal <= '0;
            hits <= '0;
            mistakes <= '0;
            lastMiss <= 1'b0;
            win <= 1'b0;
            lose <= 1'b0;
        end else if (clearScore) begin
            pendMask <= '0;
            pendCount <= '0;
            reveal <= '0;
            hits <= '0;
            mistakes <= '0;
            lastMiss <= 1'b0;
            win <= 1'b0;
            lose <= 1'b0;
        end else if (commit) begin
            pendMask <= '0;
            pendCount <= '0;
            reveal <= revealNext;
            // hit counter saturates at 7
            hits <= hitSum[mistakeWidth] ? '1 : hitSum[mistakeWidth-1:0];
            mistakes <= mistakesNext;
            lastMiss <= (countNext == '0);
            // flags stick until the next start
            win <= win || winNext;
            lose <= lose || (!winNext && (int'(mistakesNext) >= maxMistakes));
        end else begin
            pendMask <= maskNext;
            pendCount <= countNext;
        end
    end

endmodule

//--- src/hangmanTop.sv
// ~~~~~~~~~~~~~~~~~~~~
// top level of the game core
// APB slave, round FSM, compare, score
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module hangmanTop #(
    parameter int maxMistakes = 6
) (
    input  logic clk,
    input  logic nRst,
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic [7:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic pready,
    output logic pslverr
);
    import hangmanPkg::*;

    // register strobes
    logic wordWrLo;
    logic wordWrHi;
    logic [31:0] wordData;
    logic startWr;
    logic guessWr;
    logic [letterWidth-1:0] guessData;

    // FSM control
    logic [2:0] scanIndex;
    logic scanEn;
    logic hitValid;
    logic clearScore;
    logic commit;
    logic busy;
    logic ready;
    logic playing;
    logic hit;

    // score
    logic [letterCount-1:0] reveal;
    logic [mistakeWidth-1:0] hits;
    logic [mistakeWidth-1:0] mistakes;
    logic lastMiss;
    logic win;
    logic lose;

    apbRegs i_apbRegs (
        .clk(clk), .nRst(nRst), .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata), .busy(busy), .ready(ready), .playing(playing),
        .reveal(reveal), .hits(hits), .mistakes(mistakes), .lastMiss(lastMiss),
        .win(win), .lose(lose), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .wordWrLo(wordWrLo), .wordWrHi(wordWrHi), .wordData(wordData),
        .startWr(startWr), .guessWr(guessWr), .guessData(guessData)
    );

    gameControl i_gameControl (
        .clk(clk), .nRst(nRst), .startWr(startWr), .guessWr(guessWr),
        .win(win), .lose(lose), .scanIndex(scanIndex), .scanEn(scanEn),
        .hitValid(hitValid), .clearScore(clearScore), .commit(commit),
        .busy(busy), .ready(ready), .playing(playing)
    );

    letterMatch i_letterMatch (
        .clk(clk), .nRst(nRst), .wordWrLo(wordWrLo), .wordWrHi(wordWrHi),
        .wordData(wordData), .guessWr(guessWr), .guessData(guessData),
        .scanIndex(scanIndex), .scanEn(scanEn), .hit(hit)
    );

    scoreKeeper #(
        .maxMistakes(maxMistakes)
    ) i_scoreKeeper (
        .clk(clk), .nRst(nRst), .clearScore(clearScore), .hitValid(hitValid),
        .hit(hit), .scanIndex(scanIndex), .commit(commit), .reveal(reveal),
        .hits(hits), .mistakes(mistakes), .lastMiss(lastMiss), .win(win), .lose(lose)
    );

endmodule

//--- tests/scoreChecker.sv
// ~~~~~~~~~~~~~~~~~~~~
// APB response checker
// compares read data or pslverr with
// the expectation strobed by the testbench
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module scoreChecker (
    input  logic clk,
    input  logic nRst,
    input  logic psel,
    input  logic penable,
    input  logic pready,
    input  logic [31:0] prdata,
    input  logic pslverr,
    input  logic checkStrobe,
    input  logic checkErr,
    input  logic [31:0] checkExp,
    input  logic [127:0] checkName,
    output int passCount,
    output int failCount
);

    logic [31:0] actual;
    logic done;

    // write checks look at pslverr, read checks at prdata
    assign actual = checkErr ? {31'h0, pslverr} : prdata;
    assign done = checkStrobe && psel && penable && pready;

    // sampled on the completing edge, before any DUT register moves
    always @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            passCount <= 0;
            failCount <= 0;
        end else if (done) begin
            if (actual !== checkExp) begin
                failCount <= failCount + 1;
                if (checkErr) begin
                    $display("mismatch %s expected pslverr %0d actual %0d",
                             checkName, checkExp[0], pslverr);
                end else begin
                    $display("mismatch %s expected %h actual %h",
                             checkName, checkExp, actual);
                end
            end else begin
                passCount <= passCount + 1;
                $display("pass %s value %h", checkName, actual);
            end
        end
    end

endmodule

//--- tests/hangmanTb.sv
// ~~~~~~~~~~~~~~~~~~~~
// testbench top for the hangman core
// clock, reset, APB driver tasks,
// stim file reader, random filler word
// ~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module hangmanTb;
    import hangmanPkg::*;

    logic clk;
    logic nRst;
    logic psel;
    logic penable;
    logic pwrite;
    logic [7:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;

    // expectation for the checker, valid in the access phase
    logic checkStrobe;
    logic checkErr;
    logic [31:0] checkExp;
    logic [127:0] checkName;
    int passCount;
    int failCount;

    int errorCount;
    int busCycles;
    integer seed;
    integer fd;
    logic [letterWidth-1:0] fillWord [letterCount];

    hangmanTop #(.maxMistakes(6)) i_hangmanTop (.*);

    scoreChecker i_scoreChecker (.*);

    always #5 clk = ~clk;

    // one APB transfer, read data taken on the completing edge
    task automatic apbXfer(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                           input logic chk, input logic errChk, input logic [31:0] expected,
                           input logic [127:0] name, output logic [31:0] rdata);
        int waited;
        @(posedge clk);
        busCycles++;
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= wr;
        paddr <= addr;
        pwdata <= data;
        @(posedge clk);
        busCycles++;
        penable <= 1'b1;
        checkStrobe <= chk;
        checkErr <= errChk;
        checkExp <= expected;
        checkName <= name;
        waited = 0;
        do begin
            @(posedge clk);
            busCycles++;
            waited++;
        end while (!pready && waited < 16);
        if (!pready) begin
            $display("APB transfer to offset %h never saw pready", addr);
            errorCount++;
        end
        rdata = prdata;
        psel <= 1'b0;
        penable <= 1'b0;
        checkStrobe <= 1'b0;
    endtask

    // poll status until the guess has been scored
    task automatic waitIdle(input logic [127:0] name);
        logic [31:0] status;
        int startCycles;
        startCycles = busCycles;
        status = 32'h1;
        while (status[statusBusy] && (busCycles - startCycles) < 100) begin
            apbXfer(1'b0, addrStatus, 32'h0, 1'b0, 1'b0, 32'h0, name, status);
        end
        if (status[statusBusy]) begin
            $display("timeout: busy still high 100 cycles after guess %s", name);
            errorCount++;
        end
    endtask

    // status after the first guess of a fresh round on the filler word
    function automatic logic [31:0] freshStatus(input logic [letterWidth-1:0] letter);
        logic [letterCount-1:0] mask;
        logic [mistakeWidth-1:0] count;
        logic [31:0] st;
        mask = '0;
        count = '0;
        for (int i = 0; i < letterCount; i++) begin
            if (fillWord[i] == letter) begin
                mask[i] = 1'b1;
                count = count + 1'b1;
            end
        end
        st = '0;
        st[statusReady] = !(&mask);
        st[statusWin] = &mask;
        st[statusMiss] = (count == '0);
        st[statusHitsLsb +: mistakeWidth] = count;
        st[statusMistakesLsb +: mistakeWidth] = (count == '0) ? 3'd1 : 3'd0;
        st[statusRevealLsb +: letterCount] = mask;
        return st;
    endfunction

    task automatic runOp(input string op, input logic [127:0] name,
                         input logic [31:0] data, input logic [31:0] expv);
        logic [31:0] rdata;
        logic [31:0] word;
        logic [letterWidth-1:0] letter;
        if (op == "wlo") begin
            apbXfer(1'b1, addrWordLo, data, 1'b1, 1'b1, expv, name, rdata);
        end else if (op == "whi") begin
            apbXfer(1'b1, addrWordHi, data, 1'b1, 1'b1, expv, name, rdata);
        end else if (op == "start") begin
            apbXfer(1'b1, addrCtrl, data, 1'b1, 1'b1, expv, name, rdata);
        end else if (op == "guess") begin
            apbXfer(1'b1, addrGuess, data, 1'b1, 1'b1, expv, name, rdata);
            if (expv == 32'h0) begin
                waitIdle(name);
            end
        end else if (op == "read") begin
            apbXfer(1'b0, data[7:0], 32'h0, 1'b1, 1'b0, expv, name, rdata);
        end else if (op == "rword") begin
            // lowercase letters only, so digit guesses always miss
            for (int i = 0; i < letterCount; i++) begin
                fillWord[i] = 8'h61 + 8'($unsigned($random(seed)) % 26);
            end
            word = {fillWord[3], fillWord[2], fillWord[1], fillWord[0]};
            apbXfer(1'b1, addrWordLo, word, 1'b1, 1'b1, 32'h0, name, rdata);
            apbXfer(1'b1, addrWordHi, {24'h0, fillWord[4]}, 1'b1, 1'b1, 32'h0, name, rdata);
            apbXfer(1'b0, addrWordLo, 32'h0, 1'b1, 1'b0, word, name, rdata);
        end else if (op == "rguess") begin
            letter = fillWord[data[2:0]];
            apbXfer(1'b1, addrGuess, {24'h0, letter}, 1'b1, 1'b1, 32'h0, name, rdata);
            waitIdle(name);
            apbXfer(1'b0, addrStatus, 32'h0, 1'b1, 1'b0, freshStatus(letter), name, rdata);
        end else begin
            $display("unknown operation %s in the stim file", op);
            errorCount++;
        end
    endtask

    initial begin
        string op;
        logic [127:0] name;
        logic [31:0] data;
        logic [31:0] expv;
        logic [1023:0] restOfLine;
        int rc;
        clk = 1'b0;
        nRst = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = 8'h0;
        pwdata = 32'h0;
        checkStrobe = 1'b0;
        checkErr = 1'b0;
        checkExp = 32'h0;
        checkName = '0;
        errorCount = 0;
        busCycles = 0;
        seed = 32'h82a6_4a5d;
        repeat (16) @(posedge clk);
        nRst <= 1'b1;
        fd = $fopen("tests/hangmanStim.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/hangmanStim.txt");
            errorCount++;
        end else begin
            // a lone # opens a comment line
            while (errorCount == 0 && $fscanf(fd, "%s", op) == 1) begin
                if (op == "#") begin
                    rc = $fgets(restOfLine, fd);
                end else begin
                    rc = $fscanf(fd, "%s %h %h", name, data, expv);
                    if (rc != 3) begin
                        $display("stim line for operation %s lacks name, data or expected",
                                 op);
                        errorCount++;
                    end else begin
                        runOp(op, name, data, expv);
                    end
                end
            end
            $fclose(fd);
        end
        // let the last check land in the counters
        repeat (2) @(posedge clk);
        $display("checks passed %0d, failed %0d, other errors %0d",
                 passCount, failCount, errorCount);
        if (passCount > 0 && failCount == 0 && errorCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- tests/hangmanStim.txt
# columns: op name data expected, data and expected in hex
# write ops expect pslverr, read ops expect prdata, data of a read is the offset
# after reset
read status_reset 10 00000000
guess guess_early 61 1
# secret word apple, letter 0 in the low byte
wlo word_lo 6c707061 0
whi word_hi 00000065 0
read word_lo_rd 00 6c707061
read word_hi_rd 04 00000065
start start_1 1 0
read status_start 10 00000002
# repeated letter
guess guess_p 70 0
read status_p 10 00060202
# miss
guess guess_z 7a 0
read status_z 10 00061212
# word and start refused mid round
wlo word_busy 7a7a7a7a 1
start start_busy 1 1
read word_kept 00 6c707061
guess guess_a 61 0
read status_a 10 00071302
# win
guess guess_l 6c 0
read status_l 10 000f1402
guess guess_e 65 0
read status_win 10 001f1504
guess guess_late 61 1
# random filler word, six misses
rword fill_word 0 0
start start_2 1 0
read status_clear 10 00000002
guess miss_1 30 0
read status_m1 10 00001012
guess miss_2 31 0
guess miss_3 32 0
guess miss_4 33 0
guess miss_5 34 0
read status_m5 10 00005012
guess miss_6 35 0
read status_lose 10 00006018
guess guess_lost 61 1
start start_3 1 0
rguess fill_hit 2 0

//--- tb.f
src/hangmanPkg.sv
src/apbRegs.sv
src/gameControl.sv
src/letterMatch.sv
src/scoreKeeper.sv
src/hangmanTop.sv
tests/scoreChecker.sv
tests/hangmanTb.sv

//--- Makefile
# Verilator build and run for the hangman core testbench
# usage: make lint | make sim | make clean

VERILATOR ?= verilator
TB_TOP    ?= hangmanTb
RTL_TOP   ?= hangmanTop
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
SIM_FLAGS ?= --binary -j 0
RTL_SRCS  ?= $(shell grep '^src/' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timescale $(TIMESCALE) --top-module $(RTL_TOP) $(RTL_SRCS)

sim:
	$(VERILATOR) $(SIM_FLAGS) --timescale $(TIMESCALE) --top-module $(TB_TOP) \
		-f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TB_TOP)
	-./$(OBJ_DIR)/V$(TB_TOP) | tee $(LOG)
	@grep -qx "TESTS PASSED" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
